// ==== common/bp_pkg.sv ====
package bp_pkg;

    // ####################
    // Widths
    // ####################

    localparam int unsigned addr_w = 30;  // Fetch address
    localparam int unsigned bh_w   = 16;  // Global history
    localparam int unsigned idx_w  = 8;   // BTB index, 256 entries
    localparam int unsigned tag_w  = 12;  // BTB tag

    // ####################
    // Resolve port
    // ####################

    // Branch outcome returned by the back end
    typedef struct packed {
        logic              valid;   // One-cycle strobe
        logic              taken;
        logic [addr_w-1:0] pc;
        logic [bh_w-1:0]   bh;      // History seen at prediction time
        logic [addr_w-1:0] target;
    } resolve_t;

    // ####################
    // BTB entry
    // ####################

    typedef struct packed {
        logic [addr_w-1:0] target;
        logic [tag_w-1:0]  tag;
    } btb_entry_t;

    // Contents of every word after configuration
    localparam btb_entry_t btb_init_entry = '{
        target: 30'h0700_0002,
        tag:    '0
    };

endpackage

// ==== design/pc_hash.sv ====
module pc_hash #(
    parameter int unsigned ADDR_W = bp_pkg::addr_w,
    parameter int unsigned TAG_W  = bp_pkg::tag_w
) (
    input  logic [ADDR_W-1:0] pc,
    output logic [TAG_W-1:0]  tag
);

    // Number of TAG_W slices, top one zero-padded
    localparam int unsigned N_SLICE = (ADDR_W + TAG_W - 1) / TAG_W;
    localparam int unsigned PAD_W   = N_SLICE * TAG_W;

    logic [PAD_W-1:0] pc_pad;

    assign pc_pad = PAD_W'(pc);

    // XOR fold of all slices
    always_comb begin
        tag = '0;
        for (int i = 0; i < N_SLICE; i++) begin
            tag ^= pc_pad[i*TAG_W +: TAG_W];
        end
    end

endmodule

// ==== design/pc_bh_hash.sv ====
module pc_bh_hash #(
    parameter int unsigned ADDR_W = bp_pkg::addr_w,
    parameter int unsigned BH_W   = bp_pkg::bh_w,
    parameter int unsigned IDX_W  = bp_pkg::idx_w
) (
    input  logic [ADDR_W-1:0] pc,
    input  logic [BH_W-1:0]   bh,
    output logic [IDX_W-1:0]  idx
);

    logic [IDX_W-1:0] bh_fold;  // History squeezed to index width
    logic [IDX_W-1:0] pc_low;

    // Oldest and youngest history bits both reach the index
    assign bh_fold = bh[IDX_W-1:0] ^ bh[BH_W-1 -: IDX_W];

    assign pc_low = pc[IDX_W-1:0];

    // Same pc lands on different entries for different paths
    assign idx = pc_low ^ bh_fold;

endmodule

// ==== design/ghr.sv ====
module ghr #(
    parameter int unsigned BH_W = bp_pkg::bh_w
) (
    input  logic             clk,
    input  logic             rst_n,
    input  bp_pkg::resolve_t resolve,
    output logic [BH_W-1:0]  bh
);

    logic [BH_W-1:0] bh_q;
    logic [BH_W-1:0] bh_next;

    // ####################
    // Shift on resolve
    // ####################

    // Youngest outcome at bit 0, oldest drops out the top
    always_comb begin
        bh_next = bh_q;
        if (resolve.valid) begin
            bh_next = {bh_q[BH_W-2:0], resolve.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bh_q <= '0;
        end else begin
            bh_q <= bh_next;
        end
    end

    assign bh = bh_q;

endmodule

// ==== btb/sp_bram.sv ====
module sp_bram #(
    parameter int unsigned IDX_W = bp_pkg::idx_w
) (
    input  logic               clk,
    // Read port
    input  logic               ren,
    input  logic [IDX_W-1:0]   raddr,
    output bp_pkg::btb_entry_t dout,
    // Write port
    input  logic               we,
    input  logic [IDX_W-1:0]   waddr,
    input  bp_pkg::btb_entry_t din
);

    import bp_pkg::*;

    localparam int unsigned DEPTH = 2 ** IDX_W;

    // Preset image of every word
    btb_entry_t mem [DEPTH] = '{default: btb_init_entry};

    // ####################
    // Registered read
    // ####################

    // Read-first output held while ren is low
    always_ff @(posedge clk) begin
        if (ren) begin
            dout <= mem[raddr];
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

endmodule

// ==== btb/btb.sv ====
module btb #(
    parameter int unsigned ADDR_W = bp_pkg::addr_w,
    parameter int unsigned BH_W   = bp_pkg::bh_w,
    parameter int unsigned IDX_W  = bp_pkg::idx_w,
    parameter int unsigned TAG_W  = bp_pkg::tag_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic [ADDR_W-1:0] pc,
    input  logic [BH_W-1:0]   bh,
    input  bp_pkg::resolve_t  resolve,
    output logic [ADDR_W-1:0] npc_pred
);

    import bp_pkg::*;

    logic [ADDR_W-1:0] pc_q;      // Address of the pending lookup
    logic [IDX_W-1:0]  lkp_idx;
    logic [TAG_W-1:0]  lkp_tag;
    logic [IDX_W-1:0]  upd_idx;
    logic [TAG_W-1:0]  upd_tag;
    logic              rd_en;
    logic              upd_en;
    logic              hit;
    logic [ADDR_W-1:0] fall_thru;
    btb_entry_t        rd_entry;
    btb_entry_t        wr_entry;

    // ####################
    // Hashing
    // ####################

    pc_bh_hash #(.ADDR_W(ADDR_W), .BH_W(BH_W), .IDX_W(IDX_W)) u_lkp_idx_hash (
        .pc  (pc),
        .bh  (bh),
        .idx (lkp_idx)
    );

    pc_bh_hash #(.ADDR_W(ADDR_W), .BH_W(BH_W), .IDX_W(IDX_W)) u_upd_idx_hash (
        .pc  (resolve.pc),
        .bh  (resolve.bh),
        .idx (upd_idx)
    );

    // Tag of the registered address, compared next to the read data
    pc_hash #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) u_lkp_tag_hash (
        .pc  (pc_q),
        .tag (lkp_tag)
    );

    pc_hash #(.ADDR_W(ADDR_W), .TAG_W(TAG_W)) u_upd_tag_hash (
        .pc  (resolve.pc),
        .tag (upd_tag)
    );

    // ####################
    // Table access
    // ####################

    assign rd_en    = ~stall;
    assign upd_en   = resolve.valid & resolve.taken;  // Not-taken only moves history
    assign wr_entry = '{target: resolve.target, tag: upd_tag};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (rd_en) begin
            pc_q <= pc;
        end
    end

    sp_bram #(.IDX_W(IDX_W)) u_table (
        .clk   (clk),
        .ren   (rd_en),
        .raddr (lkp_idx),
        .dout  (rd_entry),
        .we    (upd_en),
        .waddr (upd_idx),
        .din   (wr_entry)
    );

    // Odd address steps by one, even by two
    assign fall_thru = pc_q[0] ? pc_q + ADDR_W'(1) : pc_q + ADDR_W'(2);
    assign hit       = (rd_entry.tag == lkp_tag);
    assign npc_pred  = hit ? rd_entry.target : fall_thru;

endmodule

// ==== design/bp_top.sv ====
module bp_top #(
    parameter int unsigned ADDR_W = bp_pkg::addr_w,
    parameter int unsigned BH_W   = bp_pkg::bh_w,
    parameter int unsigned IDX_W  = bp_pkg::idx_w,
    parameter int unsigned TAG_W  = bp_pkg::tag_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic [ADDR_W-1:0] fetch_pc,
    input  bp_pkg::resolve_t  resolve,   // Back-end branch outcome
    output logic [ADDR_W-1:0] npc_pred,
    output logic [BH_W-1:0]   pred_bh    // Travels with the branch, comes back in resolve.bh
);

    logic [BH_W-1:0] cur_bh;

    // ####################
    // History
    // ####################

    ghr #(
        .BH_W (BH_W)
    ) u_ghr (
        .clk     (clk),
        .rst_n   (rst_n),
        .resolve (resolve),
        .bh      (cur_bh)
    );

    // ####################
    // Target buffer
    // ####################

    btb #(
        .ADDR_W (ADDR_W),
        .BH_W   (BH_W),
        .IDX_W  (IDX_W),
        .TAG_W  (TAG_W)
    ) u_btb (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .pc       (fetch_pc),
        .bh       (cur_bh),     // Same history as handed out
        .resolve  (resolve),
        .npc_pred (npc_pred)
    );

    assign pred_bh = cur_bh;

endmodule

// ==== dv/bp_asserts.sv ====
module bp_asserts #(
    parameter int unsigned ADDR_W = bp_pkg::addr_w,
    parameter int unsigned BH_W   = bp_pkg::bh_w
) (
    input logic              clk,
    input logic              rst_n,
    input logic              stall,
    input bp_pkg::resolve_t  resolve,
    input logic [ADDR_W-1:0] npc_pred,
    input logic [BH_W-1:0]   pred_bh
);

    timeunit 1ns;
    timeprecision 1ps;

    import bp_pkg::*;

    int unsigned fail_cnt = 0;  // Failed assertion attempts

    // ####################
    // Reset and history
    // ####################

    // First edge out of reset sees an empty history and the preset target of address 0
    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (pred_bh == '0 && npc_pred == ADDR_W'(btb_init_entry.target)))
    else begin
        $error("state after reset is not the cleared history and preset target");
        fail_cnt++;
    end

    a_bh_shift: assert property (@(posedge clk) disable iff (!rst_n)
        resolve.valid |=> pred_bh == {$past(pred_bh[BH_W-2:0]), $past(resolve.taken)})
    else begin
        $error("history did not shift in the resolved taken bit");
        fail_cnt++;
    end

    a_bh_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !resolve.valid |=> pred_bh == $past(pred_bh))
    else begin
        $error("history changed without a resolve");
        fail_cnt++;
    end

    // ####################
    // Stall
    // ####################

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> npc_pred == $past(npc_pred))
    else begin
        $error("prediction changed across a stalled edge");
        fail_cnt++;
    end

endmodule

bind bp_top bp_asserts #(
    .ADDR_W (ADDR_W),
    .BH_W   (BH_W)
) u_bp_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .resolve  (resolve),
    .npc_pred (npc_pred),
    .pred_bh  (pred_bh)
);

// ==== dv/bp_tb.sv ====
module bp_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import bp_pkg::*;

    localparam int unsigned WAIT_CYC = 8;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              stall;
    logic [addr_w-1:0] fetch_pc;
    resolve_t          resolve;
    logic [addr_w-1:0] npc_pred;
    logic [bh_w-1:0]   pred_bh;

    // ####################
    // Reference model
    // ####################

    btb_entry_t        model_mem [2**idx_w];
    logic [bh_w-1:0]   exp_bh;
    logic [addr_w-1:0] exp_npc;

    // Inputs driven at the last edge, sampled at the next one
    logic              pend_stall;
    logic [addr_w-1:0] pend_pc;
    resolve_t          pend_res;

    logic [15:0]       lfsr_q = 16'd99;
    string             test_name = "reset";
    bit                chk_on = 1'b0;
    int unsigned       val_errs = 0;
    int unsigned       timeouts = 0;
    int unsigned       assert_errs;

    always #2 clk = ~clk;

    bp_top i_bp_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .fetch_pc (fetch_pc),
        .resolve  (resolve),
        .npc_pred (npc_pred),
        .pred_bh  (pred_bh)
    );

    // Taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [tag_w-1:0] tag_of(input logic [addr_w-1:0] pc);
        return pc[11:0] ^ pc[23:12] ^ {6'b0, pc[29:24]};
    endfunction

    function automatic logic [idx_w-1:0] idx_of(input logic [addr_w-1:0] pc,
                                                input logic [bh_w-1:0]   bh);
        return pc[7:0] ^ bh[7:0] ^ bh[15:8];
    endfunction

    function automatic logic [addr_w-1:0] fall_through(input logic [addr_w-1:0] pc);
        return pc[0] ? pc + addr_w'(1) : pc + addr_w'(2);
    endfunction

    function automatic resolve_t make_res(input logic taken, input logic [addr_w-1:0] pc,
                                          input logic [bh_w-1:0] bh,
                                          input logic [addr_w-1:0] target);
        return '{valid: 1'b1, taken: taken, pc: pc, bh: bh, target: target};
    endfunction

    // Model of one clock edge with read before write
    task automatic apply_model(input logic s, input logic [addr_w-1:0] p, input resolve_t r);
        btb_entry_t e;
        if (!s) begin
            e       = model_mem[idx_of(p, exp_bh)];
            exp_npc = (e.tag == tag_of(p)) ? e.target : fall_through(p);
        end
        if (r.valid) begin
            if (r.taken) begin
                model_mem[idx_of(r.pc, r.bh)] = '{target: r.target, tag: tag_of(r.pc)};
            end
            exp_bh = {exp_bh[bh_w-2:0], r.taken};
        end
    endtask

    task automatic run_cycle(input logic s, input logic [addr_w-1:0] p, input resolve_t r);
        @(posedge clk);
        apply_model(pend_stall, pend_pc, pend_res);
        stall      <= s;
        fetch_pc   <= p;
        resolve    <= r;
        pend_stall = s;
        pend_pc    = p;
        pend_res   = r;
        @(negedge clk);
    endtask

    // Stalled cycles until the last lookup shows up
    task automatic await_npc(input logic [addr_w-1:0] expect_val);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < WAIT_CYC && !seen; n++) begin
            run_cycle(1'b1, addr_w'(take_bits(addr_w)), '0);
            seen = (npc_pred == expect_val);
        end
        if (!seen) begin
            $display("%s: prediction never reached %h within %0d cycles",
                     test_name, expect_val, WAIT_CYC);
            timeouts++;
        end
    endtask

    always @(negedge clk) begin
        if (chk_on) begin
            if (npc_pred !== exp_npc) begin
                $display("ERR %s: npc_pred expected %h actual %h", test_name, exp_npc, npc_pred);
                val_errs++;
            end
            if (pred_bh !== exp_bh) begin
                $display("ERR %s: pred_bh expected %h actual %h", test_name, exp_bh, pred_bh);
                val_errs++;
            end
        end
    end

    initial begin
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] addr2;
        logic [addr_w-1:0] tgt;
        logic [bh_w-1:0]   nxt_bh;
        logic              s;
        resolve_t          res;
        rst_n      = 1'b0;
        stall      = 1'b0;
        fetch_pc   = '0;
        resolve    = '0;
        pend_stall = 1'b0;
        pend_pc    = '0;
        pend_res   = '0;
        exp_bh     = '0;
        exp_npc    = btb_init_entry.target;
        foreach (model_mem[i]) begin
            model_mem[i] = btb_init_entry;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        chk_on = 1'b1;

        test_name = "miss";
        run_cycle(1'b0, 30'h0123_4567, '0);  // Odd
        await_npc(fall_through(30'h0123_4567));
        run_cycle(1'b0, 30'h00AB_CDE2, '0);  // Even
        await_npc(fall_through(30'h00AB_CDE2));
        for (int i = 0; i < 24; i++) begin
            run_cycle(1'b0, addr_w'(take_bits(addr_w)), '0);
        end

        test_name = "hit";
        addr = 30'h0345_6789;
        tgt  = 30'h0111_2220;
        run_cycle(1'b0, addr, make_res(1'b1, addr, exp_bh, tgt));  // Same index read and write
        await_npc(fall_through(addr));
        nxt_bh = {exp_bh[bh_w-2:0], 1'b1};
        run_cycle(1'b1, addr, make_res(1'b1, addr, nxt_bh, tgt));
        run_cycle(1'b0, addr, '0);
        await_npc(tgt);

        test_name = "history";
        addr   = 30'h0246_8ACE;
        nxt_bh = {exp_bh[bh_w-2:0], 1'b0};
        run_cycle(1'b1, addr, make_res(1'b0, addr, nxt_bh, 30'h0155_5550));
        run_cycle(1'b0, addr, '0);
        await_npc(fall_through(addr));  // Not-taken wrote nothing
        for (int i = 0; i < 32; i++) begin
            addr      = addr_w'(take_bits(addr_w));
            tgt       = addr_w'(take_bits(addr_w));
            nxt_bh    = bh_w'(take_bits(bh_w));
            res       = make_res(1'(take_bits(1)), addr, nxt_bh, tgt);
            res.valid = 1'(take_bits(1));
            run_cycle(1'b0, addr_w'(take_bits(addr_w)), res);
        end
        run_cycle(1'b0, '0, '0);

        test_name = "stall";
        addr = 30'h0159_D3B5;
        tgt  = 30'h02C0_FFE0;
        run_cycle(1'b0, addr, '0);
        // Held entry rewritten with a matching tag
        run_cycle(1'b1, addr_w'(take_bits(addr_w)), make_res(1'b1, addr, exp_bh, tgt));
        run_cycle(1'b1, addr_w'(take_bits(addr_w)), '0);
        run_cycle(1'b1, addr_w'(take_bits(addr_w)), '0);
        for (int i = 0; i < 32; i++) begin
            s         = (take_bits(2) != 0);
            addr      = addr_w'(take_bits(addr_w));
            tgt       = addr_w'(take_bits(addr_w));
            res       = make_res(1'b1, addr, exp_bh, tgt);
            res.valid = 1'(take_bits(1));
            run_cycle(s, addr_w'(take_bits(addr_w)), res);
        end
        run_cycle(1'b0, '0, '0);

        test_name = "alias";
        addr   = 30'h0135_7911;
        addr2  = addr ^ 30'h0000_1000;  // Same index with another tag
        nxt_bh = {exp_bh[bh_w-3:0], 2'b11};  // History once both writes are in
        run_cycle(1'b1, addr, make_res(1'b1, addr, nxt_bh, 30'h0A0A_0A08));
        run_cycle(1'b1, addr2, make_res(1'b1, addr2, nxt_bh, 30'h0505_0504));
        run_cycle(1'b0, addr, '0);
        await_npc(fall_through(addr));
        run_cycle(1'b0, addr2, '0);
        await_npc(30'h0505_0504);
        nxt_bh = {nxt_bh[bh_w-2:0], 1'b1};
        run_cycle(1'b1, addr, make_res(1'b1, addr, nxt_bh, 30'h0A0A_0A08));
        run_cycle(1'b0, addr2, '0);
        await_npc(fall_through(addr2));
        run_cycle(1'b0, addr, '0);
        await_npc(30'h0A0A_0A08);

        run_cycle(1'b0, '0, '0);
        run_cycle(1'b1, '0, '0);
        assert_errs = i_bp_top.u_bp_asserts.fail_cnt;
        $display("errors: value %0d, timeout %0d, assertion %0d",
                 val_errs, timeouts, assert_errs);
        if (val_errs == 0 && timeouts == 0 && assert_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/bp_pkg.sv
design/pc_hash.sv
design/pc_bh_hash.sv
design/ghr.sv
btb/sp_bram.sv
btb/btb.sv
design/bp_top.sv
dv/bp_asserts.sv
dv/bp_tb.sv

// ==== Bender.yml ====
package:
  name: bp

sources:
  - files:
      - common/bp_pkg.sv
      - design/pc_hash.sv
      - design/pc_bh_hash.sv
      - design/ghr.sv
      - btb/sp_bram.sv
      - btb/btb.sv
      - design/bp_top.sv
  - target: test
    files:
      - dv/bp_asserts.sv
      - dv/bp_tb.sv
